/* common/lcd_pkg.sv */
package lcd_pkg;

    // visible area, kept small for simulation
    localparam int H_ACTIVE = 64;
    localparam int V_ACTIVE = 6;
    localparam int H_BLANK  = 16;   // pixel slots
    localparam int V_BLANK  = 2;    // lines
    localparam int H_TOTAL  = H_ACTIVE + H_BLANK;
    localparam int V_TOTAL  = V_ACTIVE + V_BLANK;

    localparam int POP_DIV = 4;     // clocks per pixel slot
    localparam int DIV_W   = $clog2(POP_DIV);

    localparam int X_W = 9;
    localparam int Y_W = 7;

    // rgb666
    typedef struct packed {
        logic [5:0] r;
        logic [5:0] g;
        logic [5:0] b;
    } pixel_t;

    typedef struct packed {
        logic [X_W-1:0] x;
        logic [Y_W-1:0] y;
        logic           hsync;  // line blanking
        logic           vsync;  // frame blanking
        logic           pop;    // one-clock pixel request
    } scan_t;

endpackage

/* common/fb_pkg.sv */
package fb_pkg;

    localparam int BURST_LEN = 8;   // words per read command
    localparam int IDX_W     = $clog2(BURST_LEN);
    localparam int ADDR_W    = 16;  // y in [15:9], x in [8:0]

    localparam int RD_DEPTH  = 16;
    localparam int CMD_DEPTH = 4;

    // framebuffer word, colour in the top six bits of byte lanes 2..0
    typedef struct packed {
        logic [7:0] rsvd3;
        logic [5:0] r;
        logic [1:0] rsvd2;
        logic [5:0] g;
        logic [1:0] rsvd1;
        logic [5:0] b;
        logic [1:0] rsvd0;
    } word_t;

    typedef struct packed {
        logic              read;
        logic [ADDR_W-1:0] addr;
    } mem_cmd_t;

endpackage

/* mem/sync_fifo.sv */
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push_i,
    input  payload_t data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t data_o,
    output logic     empty_o
);

    localparam int PTR_W = $clog2(DEPTH);

    payload_t       mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    assign full_o  = (count_q == (PTR_W + 1)'(DEPTH));
    assign empty_o = (count_q == '0);
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;
    assign data_o  = mem_q[rd_ptr_q];   // head shown before pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst) push_i |-> !full_o);
    a_no_underflow: assert property (@(posedge clk) disable iff (rst) pop_i |-> !empty_o);

endmodule

/* mem/fb_mem_port.sv */
`timescale 1ns/1ns

module fb_mem_port import fb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              cmd_en_i,
    input  mem_cmd_t          cmd_i,
    output logic              cmd_full_o,
    input  logic              rd_en_i,
    output word_t             rd_data_o,
    output logic              rd_empty_o,
    input  logic              host_we_i,
    input  logic [ADDR_W-1:0] host_addr_i,
    input  word_t             host_data_i
);

    typedef enum logic [1:0] {
        BE_IDLE,
        BE_WAIT,
        BE_BURST
    } burst_state_t;

    word_t             ram_q [2**ADDR_W];
    word_t             ram_rd;
    mem_cmd_t          head_cmd;
    logic              cmd_push;
    logic              cmd_pop;
    logic              cmd_empty;
    logic              rd_pop;
    logic              rd_push;
    logic              rd_full;
    burst_state_t      be_state_q;
    logic [ADDR_W-1:0] be_addr_q;
    logic [IDX_W-1:0]  be_cnt_q;

    assign cmd_push = cmd_en_i && !cmd_full_o;
    assign cmd_pop  = (be_state_q == BE_IDLE) && !cmd_empty;
    assign rd_push  = (be_state_q == BE_BURST) && !rd_full;   // pause on full
    assign rd_pop   = rd_en_i && !rd_empty_o;
    assign ram_rd   = ram_q[be_addr_q];

    sync_fifo #(
        .payload_t (mem_cmd_t),
        .DEPTH     (CMD_DEPTH)
    ) u_cmd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (cmd_push),
        .data_i  (cmd_i),
        .full_o  (cmd_full_o),
        .pop_i   (cmd_pop),
        .data_o  (head_cmd),
        .empty_o (cmd_empty)
    );

    sync_fifo #(
        .payload_t (word_t),
        .DEPTH     (RD_DEPTH)
    ) u_rd_fifo (
        .clk     (clk),
        .rst     (rst),
        .push_i  (rd_push),
        .data_i  (ram_rd),
        .full_o  (rd_full),
        .pop_i   (rd_pop),
        .data_o  (rd_data_o),
        .empty_o (rd_empty_o)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            be_state_q <= BE_IDLE;
            be_cnt_q   <= '0;
        end else begin
            case (be_state_q)
                BE_IDLE: begin
                    if (cmd_pop && head_cmd.read) begin
                        be_state_q <= BE_WAIT;  // other commands are dropped
                    end
                end
                BE_WAIT: be_state_q <= BE_BURST;
                BE_BURST: begin
                    if (rd_push) begin
                        be_cnt_q <= be_cnt_q + 1'b1;
                        if (be_cnt_q == IDX_W'(BURST_LEN - 1)) begin
                            be_state_q <= BE_IDLE;
                        end
                    end
                end
                default: be_state_q <= BE_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            be_addr_q <= head_cmd.addr;
        end else if (rd_push) begin
            be_addr_q <= be_addr_q + 1'b1;
        end
    end

    // host fill port
    always_ff @(posedge clk) begin
        if (host_we_i) begin
            ram_q[host_addr_i] <= host_data_i;
        end
    end

endmodule

/* rtl/lcd_scan_counter.sv */
`timescale 1ns/1ns

module lcd_scan_counter import lcd_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    output scan_t scan_o
);

    logic [DIV_W-1:0] div_q;
    logic [X_W-1:0]   x_q;
    logic [Y_W-1:0]   y_q;
    logic             pop;

    assign pop = (div_q == DIV_W'(POP_DIV - 2));

    always_ff @(posedge clk) begin
        if (rst) begin
            div_q <= '0;
            // start in the hsync of the last blank line
            // so group 0 of line 0 is the first fetch
            x_q   <= X_W'(H_ACTIVE);
            y_q   <= Y_W'(V_TOTAL - 1);
        end else begin
            div_q <= (div_q == DIV_W'(POP_DIV - 1)) ? '0 : div_q + 1'b1;
            if (pop) begin
                if (x_q == X_W'(H_TOTAL - 1)) begin
                    x_q <= '0;
                    y_q <= (y_q == Y_W'(V_TOTAL - 1)) ? '0 : y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
        end
    end

    assign scan_o.x     = x_q;
    assign scan_o.y     = y_q;
    assign scan_o.hsync = (x_q >= X_W'(H_ACTIVE));
    assign scan_o.vsync = (y_q >= Y_W'(V_ACTIVE));
    assign scan_o.pop   = pop;

    // one pixel slot is never shorter than two clocks
    a_pop_spaced: assert property (@(posedge clk) disable iff (rst) pop |=> !pop);

endmodule

/* prefetch/fb_prefetch_fsm.sv */
`timescale 1ns/1ns

module fb_prefetch_fsm import lcd_pkg::*, fb_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  scan_t            scan_i,
    output logic             cmd_en_o,
    output mem_cmd_t         cmd_o,
    input  logic             cmd_full_i,
    output logic             rd_en_o,
    input  word_t            rd_data_i,
    input  logic             rd_empty_i,
    output logic             wr_en_o,
    output logic             wr_bank_o,
    output logic [IDX_W-1:0] wr_idx_o,
    output pixel_t           wr_pix_o,
    output logic             side_o,
    output logic             underrun_o
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_COLLECT
    } state_t;

    state_t           state_q;
    logic [X_W-1:0]   tgt_x_q;
    logic [Y_W-1:0]   tgt_y_q;
    logic [IDX_W-1:0] idx_q;
    logic             side_q;
    logic             swap_pend_q;  // fill done, waiting for end of shown group
    logic             underrun_q;
    logic             wr_en_q;
    logic             wr_bank_q;
    logic [IDX_W-1:0] wr_idx_q;
    pixel_t           wr_pix_q;

    logic [Y_W-1:0] next_y;
    logic           line_req;
    logic           group_req;
    logic           req;
    logic           group_end;

    assign next_y = (scan_i.y == Y_W'(V_TOTAL - 1)) ? '0 : scan_i.y + 1'b1;

    // group 0 of the next line, on the first hsync slot only
    assign line_req = scan_i.pop && scan_i.x == X_W'(H_ACTIVE) && next_y < Y_W'(V_ACTIVE);

    assign group_req = scan_i.pop && !scan_i.hsync && !scan_i.vsync
                       && scan_i.x[IDX_W-1:0] == '0
                       && scan_i.x < X_W'(H_ACTIVE - BURST_LEN);

    assign req       = line_req || group_req;
    assign group_end = scan_i.pop && scan_i.x[IDX_W-1:0] == IDX_W'(BURST_LEN - 1);

    assign rd_en_o = (state_q == ST_COLLECT) && !rd_empty_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= ST_IDLE;
            idx_q       <= '0;
            side_q      <= 1'b0;
            swap_pend_q <= 1'b0;
            underrun_q  <= 1'b0;
            wr_en_q     <= 1'b0;
        end else begin
            wr_en_q <= rd_en_o;
            if (req && (state_q != ST_IDLE || swap_pend_q)) begin
                underrun_q <= 1'b1;   // sticky
            end
            // swap after the last pixel of the group on screen
            if (group_end && swap_pend_q) begin
                side_q      <= ~side_q;
                swap_pend_q <= 1'b0;
            end
            case (state_q)
                ST_IDLE: begin
                    if (req && !swap_pend_q) begin
                        state_q <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (!cmd_full_i) begin
                        state_q <= ST_COLLECT;
                        idx_q   <= '0;
                    end
                end
                ST_COLLECT: begin
                    if (rd_en_o) begin
                        idx_q <= idx_q + 1'b1;
                        if (idx_q == IDX_W'(BURST_LEN - 1)) begin
                            state_q     <= ST_IDLE;
                            swap_pend_q <= 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && req) begin
            tgt_x_q <= line_req ? '0 : scan_i.x + X_W'(BURST_LEN);
            tgt_y_q <= line_req ? next_y : scan_i.y;
        end
        if (rd_en_o) begin
            wr_bank_q <= ~side_q;   // fill the hidden bank
            wr_idx_q  <= idx_q;
            wr_pix_q  <= pixel_t'{r: rd_data_i.r, g: rd_data_i.g, b: rd_data_i.b};
        end
    end

    assign cmd_en_o   = (state_q == ST_ISSUE);
    assign cmd_o      = mem_cmd_t'{read: 1'b1, addr: {tgt_y_q, tgt_x_q}};
    assign wr_en_o    = wr_en_q;
    assign wr_bank_o  = wr_bank_q;
    assign wr_idx_o   = wr_idx_q;
    assign wr_pix_o   = wr_pix_q;
    assign side_o     = side_q;
    assign underrun_o = underrun_q;

    // a word never lands in a bank that is still waiting to be shown
    a_rd_in_collect: assert property (@(posedge clk) disable iff (rst)
        rd_en_o |-> state_q == ST_COLLECT && !swap_pend_q);

endmodule

/* prefetch/pixel_line_cache.sv */
`timescale 1ns/1ns

module pixel_line_cache import lcd_pkg::*, fb_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             wr_en_i,
    input  logic             wr_bank_i,
    input  logic [IDX_W-1:0] wr_idx_i,
    input  pixel_t           wr_pix_i,
    input  logic             side_i,
    input  scan_t            scan_i,
    output pixel_t           pix_o,
    output logic             pix_valid_o
);

    pixel_t mem_q [2*BURST_LEN];   // two banks of one group
    pixel_t pix_q;
    logic   valid_q;
    logic   active_pop;

    assign active_pop = scan_i.pop && !scan_i.hsync && !scan_i.vsync;

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem_q[{wr_bank_i, wr_idx_i}] <= wr_pix_i;
        end
        if (active_pop) begin
            pix_q <= mem_q[{side_i, scan_i.x[IDX_W-1:0]}];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= active_pop;  // blanking pops give no pixel
        end
    end

    assign pix_o       = pix_q;
    assign pix_valid_o = valid_q;

endmodule

/* rtl/fb_display_top.sv */
`timescale 1ns/1ns

module fb_display_top import lcd_pkg::*, fb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              host_we_i,
    input  logic [ADDR_W-1:0] host_addr_i,
    input  word_t             host_data_i,
    output pixel_t            pix_o,
    output logic              pix_valid_o,
    output scan_t             scan_o,
    output logic              underrun_o
);

    logic             cmd_en;
    mem_cmd_t         cmd;
    logic             cmd_full;
    logic             rd_en;
    word_t            rd_data;
    logic             rd_empty;
    logic             wr_en;
    logic             wr_bank;
    logic [IDX_W-1:0] wr_idx;
    pixel_t           wr_pix;
    logic             side;

    lcd_scan_counter u_scan (
        .clk    (clk),
        .rst    (rst),
        .scan_o (scan_o)
    );

    fb_prefetch_fsm u_prefetch (
        .clk        (clk),
        .rst        (rst),
        .scan_i     (scan_o),
        .cmd_en_o   (cmd_en),
        .cmd_o      (cmd),
        .cmd_full_i (cmd_full),
        .rd_en_o    (rd_en),
        .rd_data_i  (rd_data),
        .rd_empty_i (rd_empty),
        .wr_en_o    (wr_en),
        .wr_bank_o  (wr_bank),
        .wr_idx_o   (wr_idx),
        .wr_pix_o   (wr_pix),
        .side_o     (side),
        .underrun_o (underrun_o)
    );

    pixel_line_cache u_cache (
        .clk         (clk),
        .rst         (rst),
        .wr_en_i     (wr_en),
        .wr_bank_i   (wr_bank),
        .wr_idx_i    (wr_idx),
        .wr_pix_i    (wr_pix),
        .side_i      (side),
        .scan_i      (scan_o),
        .pix_o       (pix_o),
        .pix_valid_o (pix_valid_o)
    );

    fb_mem_port u_mem (
        .clk         (clk),
        .rst         (rst),
        .cmd_en_i    (cmd_en),
        .cmd_i       (cmd),
        .cmd_full_o  (cmd_full),
        .rd_en_i     (rd_en),
        .rd_data_o   (rd_data),
        .rd_empty_o  (rd_empty),
        .host_we_i   (host_we_i),
        .host_addr_i (host_addr_i),
        .host_data_i (host_data_i)
    );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
    output logic clk_o,
    output logic rst_o
);

    localparam int HALF_PERIOD = 10;    // 20 ns clock

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    initial begin
        rst_o = 1'b1;
        repeat (2) @(posedge clk_o);
        #2 rst_o = 1'b0;    // same offset as the other stimulus
    end

endmodule

/* bench/fb_display_tb.sv */
`timescale 1ns/1ns

module fb_display_tb import lcd_pkg::*, fb_pkg::*; ();

    localparam int CLK_NS      = 20;
    localparam int FRAME_CLKS  = H_TOTAL * V_TOTAL * POP_DIV;
    localparam int WATCHDOG_NS = (3 * FRAME_CLKS + 512) * CLK_NS;
    localparam int REWRITE_Y   = 3;     // line replaced between frames 1 and 2

    localparam int T_RESET    = 0;
    localparam int T_VALID    = 1;
    localparam int T_FRAMES   = 2;
    localparam int T_IGNORED  = 3;
    localparam int T_REWRITE  = 4;
    localparam int T_UNDERRUN = 5;
    localparam int T_SCAN     = 6;
    localparam int N_TESTS    = 7;

    logic              clk;
    logic              rst;
    logic              host_we;
    logic [ADDR_W-1:0] host_addr;
    word_t             host_data;
    pixel_t            pix;
    logic              pix_valid;
    scan_t             scan;
    logic              underrun;

    logic [31:0] fb_copy [2**ADDR_W];   // every word the host wrote
    pixel_t      new_pix [H_ACTIVE];    // colours chosen for the rewritten line
    integer      seed;
    int          chk_cnt [N_TESTS];
    int          err_cnt [N_TESTS];
    int          tests_passed;
    int          tests_failed;
    int          frame_no;
    logic        seen_active;
    logic        run_done;

    tb_clock u_clock (
        .clk_o (clk),
        .rst_o (rst)
    );

    fb_display_top uut (
        .clk         (clk),
        .rst         (rst),
        .host_we_i   (host_we),
        .host_addr_i (host_addr),
        .host_data_i (host_data),
        .pix_o       (pix),
        .pix_valid_o (pix_valid),
        .scan_o      (scan),
        .underrun_o  (underrun)
    );

    function automatic logic [ADDR_W-1:0] fb_addr(input int x, input int y);
        return {Y_W'(y), X_W'(x)};
    endfunction

    // expected pixel, decoded from the word layout by bit position
    function automatic pixel_t ref_pixel(input int x, input int y);
        logic [31:0] w;
        pixel_t      p;
        w   = fb_copy[fb_addr(x, y)];
        p.r = w[23:18];
        p.g = w[15:10];
        p.b = w[7:2];
        return p;
    endfunction

    function automatic string test_name(input int t);
        case (t)
            T_RESET:    return "reset_state";
            T_VALID:    return "valid_timing";
            T_FRAMES:   return "frame_pixels";
            T_IGNORED:  return "ignored_bits";
            T_REWRITE:  return "line_rewrite";
            T_UNDERRUN: return "no_underrun";
            default:    return "scan_timing";
        endcase
    endfunction

    task automatic write_word(input logic [ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        #2;
        host_we       = 1'b1;
        host_addr     = addr;
        host_data     = data;
        fb_copy[addr] = data;
    endtask

    task automatic end_writes();
        @(posedge clk);
        #2;
        host_we = 1'b0;
    endtask

    task automatic report_mismatch(input int t, input int x, input int y,
                                   input logic [31:0] exp, input logic [31:0] act);
        err_cnt[t]++;
        $display("MISMATCH %s at x=%0d y=%0d: expected %h, actual %h",
                 test_name(t), x, y, exp, act);
    endtask

    task automatic report_test(input int t);
        if (chk_cnt[t] == 0) begin
            $display("%s: FAIL, the test ran no checks", test_name(t));
            tests_failed++;
        end else if (err_cnt[t] == 0) begin
            $display("%s: PASS, %0d checks", test_name(t), chk_cnt[t]);
            tests_passed++;
        end else begin
            $display("%s: FAIL, %0d of %0d checks wrong", test_name(t), err_cnt[t], chk_cnt[t]);
            tests_failed++;
        end
    endtask

    initial begin : host_stimulus
        int          x;
        int          y;
        logic [31:0] w;
        host_we   = 1'b0;
        host_addr = '0;
        host_data = '0;
        seed      = 32'hfd68_d314;
        // one word per clock from time zero, far ahead of the scan rate
        for (y = 0; y < V_ACTIVE; y++) begin
            for (x = 0; x < H_ACTIVE; x++) begin
                write_word(fb_addr(x, y), $random(seed));
            end
        end
        end_writes();
        // rewrite one line in the frame blanking after frame 1
        wait (frame_no == 1);
        do begin
            @(negedge clk);
        end while (!scan.vsync);
        for (x = 0; x < H_ACTIVE; x++) begin
            w            = $random(seed);
            new_pix[x].r = w[5:0];
            new_pix[x].g = w[11:6];
            new_pix[x].b = w[17:12];
            write_word(fb_addr(x, REWRITE_Y), {8'hff, new_pix[x].r, 2'b11, new_pix[x].g,
                                               2'b11, new_pix[x].b, 2'b11});
        end
        end_writes();
    end

    // samples at the falling edge, pixel checked one clock after its pop
    initial begin : compare
        logic   prev_active;
        int     prev_x;
        int     prev_y;
        int     prev_frame;
        pixel_t exp_pix;
        int     clk_cnt;
        int     exp_x;
        int     exp_y;
        scan_t  exp_scan;
        frame_no    = -1;
        seen_active = 1'b0;
        run_done    = 1'b0;
        prev_active = 1'b0;
        prev_x      = 0;
        prev_y      = 0;
        prev_frame  = 0;
        clk_cnt     = 0;
        // first pops fall in the blanking line before line 0
        exp_x       = H_ACTIVE;
        exp_y       = V_TOTAL - 1;
        for (int t = 0; t < N_TESTS; t++) begin
            chk_cnt[t] = 0;
            err_cnt[t] = 0;
        end
        forever begin
            @(negedge clk);
            if (!rst) begin
                // pop two clocks after reset, then every POP_DIV clocks
                exp_scan.x     = X_W'(exp_x);
                exp_scan.y     = Y_W'(exp_y);
                exp_scan.hsync = (exp_x >= H_ACTIVE);
                exp_scan.vsync = (exp_y >= V_ACTIVE);
                exp_scan.pop   = ((clk_cnt % POP_DIV) == 2);
                chk_cnt[T_SCAN]++;
                if (scan !== exp_scan) begin
                    report_mismatch(T_SCAN, exp_x, exp_y, 32'(exp_scan), 32'(scan));
                end
                if (!seen_active) begin
                    chk_cnt[T_RESET]++;
                    if (pix_valid !== 1'b0 || underrun !== 1'b0) begin
                        report_mismatch(T_RESET, exp_x, exp_y, 32'd0,
                                        32'({pix_valid, underrun}));
                    end
                end
                chk_cnt[T_VALID]++;
                if (pix_valid !== prev_active) begin
                    report_mismatch(T_VALID, prev_x, prev_y, 32'(prev_active), 32'(pix_valid));
                end
                chk_cnt[T_UNDERRUN]++;
                if (underrun !== 1'b0 && err_cnt[T_UNDERRUN] == 0) begin
                    report_mismatch(T_UNDERRUN, exp_x, exp_y, 32'd0, 32'(underrun));
                end
                if (prev_active) begin
                    exp_pix = ref_pixel(prev_x, prev_y);
                    if (prev_frame < 2) begin
                        chk_cnt[T_FRAMES]++;
                        if (pix !== exp_pix) begin
                            report_mismatch(T_FRAMES, prev_x, prev_y, 32'(exp_pix), 32'(pix));
                        end
                    end else begin
                        chk_cnt[T_REWRITE]++;
                        if (pix !== exp_pix) begin
                            report_mismatch(T_REWRITE, prev_x, prev_y, 32'(exp_pix), 32'(pix));
                        end
                        if (prev_y == REWRITE_Y) begin
                            chk_cnt[T_IGNORED]++;
                            if (pix !== new_pix[prev_x]) begin
                                report_mismatch(T_IGNORED, prev_x, prev_y,
                                                32'(new_pix[prev_x]), 32'(pix));
                            end
                        end
                        if (prev_x == H_ACTIVE - 1 && prev_y == V_ACTIVE - 1) begin
                            run_done = 1'b1;
                        end
                    end
                end
                prev_active = exp_scan.pop && !exp_scan.hsync && !exp_scan.vsync;
                if (prev_active) begin
                    if (exp_x == 0 && exp_y == 0) begin
                        frame_no++;
                    end
                    seen_active = 1'b1;
                    prev_x      = exp_x;
                    prev_y      = exp_y;
                    prev_frame  = frame_no;
                end
                if (exp_scan.pop) begin
                    if (exp_x == H_TOTAL - 1) begin
                        exp_x = 0;
                        exp_y = (exp_y == V_TOTAL - 1) ? 0 : exp_y + 1;
                    end else begin
                        exp_x++;
                    end
                end
                clk_cnt++;
            end
        end
    end

    initial begin : sequencer
        tests_passed = 0;
        tests_failed = 0;
        wait (seen_active == 1'b1);
        report_test(T_RESET);
        wait (frame_no == 2);
        report_test(T_FRAMES);
        wait (run_done == 1'b1);
        report_test(T_IGNORED);
        report_test(T_REWRITE);
        report_test(T_VALID);
        report_test(T_UNDERRUN);
        report_test(T_SCAN);
        $display("summary: %0d tests passed, %0d tests failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // three frames of clocks plus a margin
    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

endmodule

/* list.f */
common/lcd_pkg.sv
common/fb_pkg.sv
mem/sync_fifo.sv
mem/fb_mem_port.sv
rtl/lcd_scan_counter.sv
prefetch/fb_prefetch_fsm.sv
prefetch/pixel_line_cache.sv
rtl/fb_display_top.sv
bench/tb_clock.sv
bench/fb_display_tb.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then judge the simulation log
verilator --binary --timing --assert --top-module fb_display_tb -f list.f -o fb_display_sim \
    && ./obj_dir/fb_display_sim > sim.log 2>&1 \
    || { echo "build or simulation run failed"; exit 1; }
grep -q "Regression failed" sim.log && { echo "failures found, see sim.log"; exit 1; } \
    || grep -q "Regression passed" sim.log
